/* design/lc4_pkg.sv */
package lc4_pkg;

   // one machine word carries data, addresses and instructions
   typedef logic [15:0] word_t;

   // register index for the eight general registers
   typedef logic [2:0] reg_idx_t;

   // condition flags, bit 2 is n, bit 1 is z, bit 0 is p
   typedef logic [2:0] nzp_t;

   // primary opcodes of the supported instruction groups
   typedef enum logic [3:0] {
      OP_BR      = 4'b0000,
      OP_ARITH   = 4'b0001,
      OP_LOGIC   = 4'b0101,
      OP_LDR     = 4'b0110,
      OP_STR     = 4'b0111,
      OP_CONST   = 4'b1001,
      OP_HICONST = 4'b1101
   } opcode_t;

   // ALU functions picked by the decoder
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOT,
      ALU_CONST,
      ALU_HICONST,
      // base plus offset for LDR, STR and BR
      ALU_ADDR
   } alu_op_t;

   // instruction field positions, each field is read downward from its msb
   localparam int OPCODE_MSB  = 15;
   localparam int RD_MSB      = 11;
   localparam int RS_MSB      = 8;
   localparam int RT_MSB      = 2;
   localparam int SUBOP_MSB   = 5;
   // immediate form of ARITH and LOGIC
   localparam int IMM_SEL_BIT = 5;

   // first fetch address after reset
   localparam word_t DEFAULT_RESET_PC = 16'h8200;

endpackage

/* design/lc4_regfile.sv */
`timescale 1ns/10ps

module lc4_regfile import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  reg_idx_t i_rs_sel,
   input  reg_idx_t i_rt_sel,
   output word_t    o_rs_data,
   output word_t    o_rt_data,
   input  logic     i_we,
   input  reg_idx_t i_wsel,
   input  word_t    i_wdata
);

   // eight general registers
   word_t regs [8];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_wsel] <= i_wdata;
      end
   end

   // write-through
   // a read of the register being written sees the new value
   assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

/* design/lc4_alu.sv */
`timescale 1ns/10ps

module lc4_alu import lc4_pkg::*; (
   input  alu_op_t i_op,
   input  word_t   i_insn,
   input  word_t   i_a,
   input  word_t   i_b,
   output word_t   o_result
);

   word_t imm5;
   word_t imm6;
   word_t imm9;
   word_t operand_b;
   word_t offset;
   logic  is_br;

   // sign-extended immediates
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   // second operand is Rt or imm5 for the ARITH and LOGIC groups
   assign operand_b = i_insn[IMM_SEL_BIT] ? imm5 : i_b;

   // branch target uses imm9, memory address uses imm6
   assign is_br  = opcode_t'(i_insn[OPCODE_MSB -: 4]) == OP_BR;
   assign offset = is_br ? imm9 : imm6;

   always_comb begin
      case (i_op)
         ALU_ADD: begin
            o_result = i_a + operand_b;
         end
         ALU_SUB: begin
            o_result = i_a - i_b;
         end
         ALU_AND: begin
            o_result = i_a & operand_b;
         end
         ALU_OR: begin
            o_result = i_a | operand_b;
         end
         ALU_XOR: begin
            o_result = i_a ^ operand_b;
         end
         ALU_NOT: begin
            o_result = ~i_a;
         end
         ALU_CONST: begin
            o_result = imm9;
         end
         ALU_HICONST: begin
            // upper byte from uimm8, low byte kept from Rd
            o_result = {i_insn[7:0], i_a[7:0]};
         end
         default: begin
            // i_a is Rs for LDR and STR, pc plus one for BR
            o_result = i_a + offset;
         end
      endcase
   end

endmodule

/* design/lc4_decode.sv */
`timescale 1ns/10ps

module lc4_decode import lc4_pkg::*; #(
   parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  word_t    i_insn,
   input  logic     i_redirect,
   input  word_t    i_target,
   output word_t    o_pc,
   output logic     o_valid,
   output word_t    o_pc_d,
   output word_t    o_insn,
   output reg_idx_t o_rs_sel,
   output reg_idx_t o_rt_sel,
   output logic     o_rs_re,
   output logic     o_rt_re,
   output reg_idx_t o_wsel,
   output logic     o_rf_we,
   output alu_op_t  o_alu_op,
   output logic     o_is_load,
   output logic     o_is_store,
   output logic     o_is_branch
);

   word_t      pc_q;
   logic       f_valid_q;
   word_t      f_pc_q;
   word_t      f_insn_q;
   opcode_t    opcode;
   logic       imm_sel;
   logic [2:0] subop;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q      <= RESET_PC;
         f_valid_q <= 1'b0;
      end else begin
         pc_q      <= i_redirect ? i_target : pc_q + 16'd1;
         // word fetched under a taken branch is dropped
         f_valid_q <= ~i_redirect;
      end
   end

   // fetch register payload
   always_ff @(posedge gwe) begin
      f_pc_q   <= pc_q;
      f_insn_q <= i_insn;
   end

   assign o_pc    = pc_q;
   assign o_pc_d  = f_pc_q;
   assign o_insn  = f_insn_q;
   // the instruction now in decode is squashed as well
   assign o_valid = f_valid_q & ~i_redirect;

   assign opcode  = opcode_t'(f_insn_q[OPCODE_MSB -: 4]);
   assign imm_sel = f_insn_q[IMM_SEL_BIT];
   assign subop   = f_insn_q[SUBOP_MSB -: 3];

   always_comb begin
      // defaults describe a no-op
      o_rs_sel    = f_insn_q[RS_MSB -: 3];
      o_rt_sel    = f_insn_q[RT_MSB -: 3];
      o_rs_re     = 1'b0;
      o_rt_re     = 1'b0;
      o_wsel      = f_insn_q[RD_MSB -: 3];
      o_rf_we     = 1'b0;
      o_alu_op    = ALU_ADD;
      o_is_load   = 1'b0;
      o_is_store  = 1'b0;
      o_is_branch = 1'b0;
      case (opcode)
         OP_BR: begin
            o_is_branch = 1'b1;
            o_alu_op    = ALU_ADDR;
         end
         OP_ARITH: begin
            // subop 00 add, 10 sub
            // MUL and DIV stay no-ops
            o_rs_re = 1'b1;
            if (imm_sel) begin
               o_rf_we = 1'b1;
            end else if (subop[1:0] == 2'b00 || subop[1:0] == 2'b10) begin
               o_rt_re  = 1'b1;
               o_rf_we  = 1'b1;
               o_alu_op = subop[1] ? ALU_SUB : ALU_ADD;
            end
         end
         OP_LOGIC: begin
            o_rs_re  = 1'b1;
            o_rf_we  = 1'b1;
            o_alu_op = ALU_AND;
            if (!imm_sel) begin
               o_rt_re = 1'b1;
               case (subop[1:0])
                  2'b00: begin
                     o_alu_op = ALU_AND;
                  end
                  2'b01: begin
                     o_alu_op = ALU_NOT;
                     o_rt_re  = 1'b0;
                  end
                  2'b10: begin
                     o_alu_op = ALU_OR;
                  end
                  default: begin
                     o_alu_op = ALU_XOR;
                  end
               endcase
            end
         end
         OP_LDR: begin
            o_rs_re   = 1'b1;
            o_rf_we   = 1'b1;
            o_alu_op  = ALU_ADDR;
            o_is_load = 1'b1;
         end
         OP_STR: begin
            // store data register sits in the Rd field
            o_rt_sel   = f_insn_q[RD_MSB -: 3];
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;
            o_alu_op   = ALU_ADDR;
            o_is_store = 1'b1;
         end
         OP_CONST: begin
            o_rf_we  = 1'b1;
            o_alu_op = ALU_CONST;
         end
         OP_HICONST: begin
            // old Rd is read on the Rs port to keep its low byte
            o_rs_sel = f_insn_q[RD_MSB -: 3];
            o_rs_re  = 1'b1;
            o_rf_we  = 1'b1;
            o_alu_op = ALU_HICONST;
         end
         default: begin
         end
      endcase
   end

   a_pc_known: assert property (@(posedge gwe) disable iff (!i_rst_n) !$isunknown(pc_q));

endmodule

/* design/lc4_execute.sv */
`timescale 1ns/10ps

module lc4_execute import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  logic     i_valid,
   input  word_t    i_pc,
   input  word_t    i_insn,
   input  reg_idx_t i_rs_sel,
   input  reg_idx_t i_rt_sel,
   input  logic     i_rs_re,
   input  logic     i_rt_re,
   input  reg_idx_t i_wsel,
   input  logic     i_rf_we,
   input  alu_op_t  i_alu_op,
   input  logic     i_is_load,
   input  logic     i_is_store,
   input  logic     i_is_branch,
   input  word_t    i_rs_data,
   input  word_t    i_rt_data,
   input  logic     i_wb_we,
   input  reg_idx_t i_wb_sel,
   input  word_t    i_wb_data,
   input  nzp_t     i_nzp_cur,
   output logic     o_valid,
   output word_t    o_pc,
   output word_t    o_insn,
   output word_t    o_alu_out,
   output word_t    o_rt_data,
   output logic     o_rf_we,
   output reg_idx_t o_wsel,
   output logic     o_is_load,
   output logic     o_is_store,
   output logic     o_redirect,
   output word_t    o_target
);

   logic     valid_q;
   logic     rf_we_q;
   logic     is_load_q;
   logic     is_store_q;
   logic     is_branch_q;
   word_t    pc_q;
   word_t    insn_q;
   reg_idx_t rs_sel_q;
   reg_idx_t rt_sel_q;
   logic     rs_re_q;
   logic     rt_re_q;
   reg_idx_t wsel_q;
   alu_op_t  alu_op_q;
   word_t    rs_q;
   word_t    rt_q;
   word_t    rs_fwd;
   word_t    rt_fwd;
   word_t    alu_a;
   word_t    alu_out;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         valid_q     <= 1'b0;
         rf_we_q     <= 1'b0;
         is_load_q   <= 1'b0;
         is_store_q  <= 1'b0;
         is_branch_q <= 1'b0;
      end else begin
         valid_q     <= i_valid;
         rf_we_q     <= i_rf_we;
         is_load_q   <= i_is_load;
         is_store_q  <= i_is_store;
         is_branch_q <= i_is_branch;
      end
   end

   always_ff @(posedge gwe) begin
      pc_q     <= i_pc;
      insn_q   <= i_insn;
      rs_sel_q <= i_rs_sel;
      rt_sel_q <= i_rt_sel;
      rs_re_q  <= i_rs_re;
      rt_re_q  <= i_rt_re;
      wsel_q   <= i_wsel;
      alu_op_q <= i_alu_op;
      rs_q     <= i_rs_data;
      rt_q     <= i_rt_data;
   end

   // forwarding from the instruction one ahead, now in result
   // distance two was already covered by regfile write-through
   assign rs_fwd = (rs_re_q && i_wb_we && i_wb_sel == rs_sel_q) ? i_wb_data : rs_q;
   assign rt_fwd = (rt_re_q && i_wb_we && i_wb_sel == rt_sel_q) ? i_wb_data : rt_q;

   // branch target is computed from pc plus one
   assign alu_a = is_branch_q ? pc_q + 16'd1 : rs_fwd;

   lc4_alu alu0 (
      .i_op     (alu_op_q),
      .i_insn   (insn_q),
      .i_a      (alu_a),
      .i_b      (rt_fwd),
      .o_result (alu_out)
   );

   // taken when any requested n/z/p bit matches the live flags
   assign o_redirect = valid_q & is_branch_q & |(insn_q[RD_MSB -: 3] & i_nzp_cur);
   assign o_target   = alu_out;

   assign o_valid    = valid_q;
   assign o_pc       = pc_q;
   assign o_insn     = insn_q;
   assign o_alu_out  = alu_out;
   assign o_rt_data  = rt_fwd;
   assign o_rf_we    = rf_we_q;
   assign o_wsel     = wsel_q;
   assign o_is_load  = is_load_q;
   assign o_is_store = is_store_q;

   // a taken branch leaves exactly two bubbles behind it
   a_redirect_squash: assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_redirect |-> o_valid ##1 !o_valid ##1 !o_valid);

endmodule

/* design/lc4_result.sv */
`timescale 1ns/10ps

module lc4_result import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  logic     i_valid,
   input  word_t    i_pc,
   input  word_t    i_insn,
   input  word_t    i_alu_out,
   input  word_t    i_rt_data,
   input  logic     i_rf_we,
   input  reg_idx_t i_wsel,
   input  logic     i_is_load,
   input  logic     i_is_store,
   input  word_t    i_dmem_rdata,
   output word_t    o_dmem_addr,
   output logic     o_dmem_we,
   output word_t    o_dmem_wdata,
   output logic     o_wb_we,
   output reg_idx_t o_wb_sel,
   output word_t    o_wb_data,
   output nzp_t     o_nzp_cur,
   output logic     o_wb_valid,
   output word_t    o_wb_pc,
   output word_t    o_wb_insn,
   output logic     o_nzp_we,
   output nzp_t     o_nzp_bits
);

   logic     valid_q;
   logic     rf_we_q;
   logic     is_load_q;
   logic     is_store_q;
   word_t    pc_q;
   word_t    insn_q;
   word_t    alu_q;
   word_t    rt_q;
   reg_idx_t wsel_q;
   nzp_t     nzp_q;
   word_t    wb_data;
   nzp_t     nzp_new;
   logic     wb_we;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         valid_q    <= 1'b0;
         rf_we_q    <= 1'b0;
         is_load_q  <= 1'b0;
         is_store_q <= 1'b0;
         // flags start at z
         nzp_q      <= 3'b010;
      end else begin
         valid_q    <= i_valid;
         rf_we_q    <= i_rf_we;
         is_load_q  <= i_is_load;
         is_store_q <= i_is_store;
         if (wb_we) begin
            nzp_q <= nzp_new;
         end
      end
   end

   always_ff @(posedge gwe) begin
      pc_q   <= i_pc;
      insn_q <= i_insn;
      alu_q  <= i_alu_out;
      rt_q   <= i_rt_data;
      wsel_q <= i_wsel;
   end

   // data memory port, address is zero for non-memory instructions
   assign o_dmem_addr  = (is_load_q | is_store_q) ? alu_q : '0;
   assign o_dmem_we    = valid_q & is_store_q;
   assign o_dmem_wdata = is_store_q ? rt_q : '0;

   // load data or ALU value
   assign wb_data = is_load_q ? i_dmem_rdata : alu_q;
   assign wb_we   = valid_q & rf_we_q;
   assign nzp_new = wb_data[15] ? 3'b100 : (wb_data == '0) ? 3'b010 : 3'b001;

   assign o_wb_we   = wb_we;
   assign o_wb_sel  = wsel_q;
   assign o_wb_data = wb_data;
   // a branch in execute sees the flags of this instruction first
   assign o_nzp_cur = wb_we ? nzp_new : nzp_q;

   // retire trace
   assign o_wb_valid = valid_q;
   assign o_wb_pc    = pc_q;
   assign o_wb_insn  = insn_q;
   assign o_nzp_we   = wb_we;
   assign o_nzp_bits = nzp_new;

   // a store retires without touching registers or flags
   a_store_only: assert property (@(posedge gwe) disable iff (!i_rst_n)
      o_dmem_we |-> o_wb_valid && !o_wb_we && !o_nzp_we);

endmodule

/* design/lc4_core.sv */
`timescale 1ns/10ps

module lc4_core import lc4_pkg::*; #(
   parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
   input  logic     gwe,
   input  logic     i_rst_n,
   output word_t    o_pc,
   input  word_t    i_insn,
   output word_t    o_dmem_addr,
   output logic     o_dmem_we,
   output word_t    o_dmem_wdata,
   input  word_t    i_dmem_rdata,
   output logic     o_wb_valid,
   output word_t    o_wb_pc,
   output word_t    o_wb_insn,
   output logic     o_rf_we,
   output reg_idx_t o_rf_wsel,
   output word_t    o_rf_data,
   output logic     o_nzp_we,
   output nzp_t     o_nzp_bits
);

   // decode to execute
   logic     d_valid;
   word_t    d_pc;
   word_t    d_insn;
   reg_idx_t d_rs_sel;
   reg_idx_t d_rt_sel;
   logic     d_rs_re;
   logic     d_rt_re;
   reg_idx_t d_wsel;
   logic     d_rf_we;
   alu_op_t  d_alu_op;
   logic     d_is_load;
   logic     d_is_store;
   logic     d_is_branch;
   word_t    rs_data;
   word_t    rt_data;
   // execute to result
   logic     e_valid;
   word_t    e_pc;
   word_t    e_insn;
   word_t    e_alu_out;
   word_t    e_rt_data;
   logic     e_rf_we;
   reg_idx_t e_wsel;
   logic     e_is_load;
   logic     e_is_store;
   // branch back to fetch
   logic     redirect;
   word_t    target;
   // register write port and live flags
   logic     wb_we;
   reg_idx_t wb_sel;
   word_t    wb_data;
   nzp_t     nzp_cur;

   lc4_decode #(
      .RESET_PC (RESET_PC)
   ) decode0 (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_insn      (i_insn),
      .i_redirect  (redirect),
      .i_target    (target),
      .o_pc        (o_pc),
      .o_valid     (d_valid),
      .o_pc_d      (d_pc),
      .o_insn      (d_insn),
      .o_rs_sel    (d_rs_sel),
      .o_rt_sel    (d_rt_sel),
      .o_rs_re     (d_rs_re),
      .o_rt_re     (d_rt_re),
      .o_wsel      (d_wsel),
      .o_rf_we     (d_rf_we),
      .o_alu_op    (d_alu_op),
      .o_is_load   (d_is_load),
      .o_is_store  (d_is_store),
      .o_is_branch (d_is_branch)
   );

   lc4_regfile regfile0 (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs_sel  (d_rs_sel),
      .i_rt_sel  (d_rt_sel),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_we      (wb_we),
      .i_wsel    (wb_sel),
      .i_wdata   (wb_data)
   );

   lc4_execute execute0 (
      .gwe         (gwe),
      .i_rst_n     (i_rst_n),
      .i_valid     (d_valid),
      .i_pc        (d_pc),
      .i_insn      (d_insn),
      .i_rs_sel    (d_rs_sel),
      .i_rt_sel    (d_rt_sel),
      .i_rs_re     (d_rs_re),
      .i_rt_re     (d_rt_re),
      .i_wsel      (d_wsel),
      .i_rf_we     (d_rf_we),
      .i_alu_op    (d_alu_op),
      .i_is_load   (d_is_load),
      .i_is_store  (d_is_store),
      .i_is_branch (d_is_branch),
      .i_rs_data   (rs_data),
      .i_rt_data   (rt_data),
      .i_wb_we     (wb_we),
      .i_wb_sel    (wb_sel),
      .i_wb_data   (wb_data),
      .i_nzp_cur   (nzp_cur),
      .o_valid     (e_valid),
      .o_pc        (e_pc),
      .o_insn      (e_insn),
      .o_alu_out   (e_alu_out),
      .o_rt_data   (e_rt_data),
      .o_rf_we     (e_rf_we),
      .o_wsel      (e_wsel),
      .o_is_load   (e_is_load),
      .o_is_store  (e_is_store),
      .o_redirect  (redirect),
      .o_target    (target)
   );

   lc4_result result0 (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_valid      (e_valid),
      .i_pc         (e_pc),
      .i_insn       (e_insn),
      .i_alu_out    (e_alu_out),
      .i_rt_data    (e_rt_data),
      .i_rf_we      (e_rf_we),
      .i_wsel       (e_wsel),
      .i_is_load    (e_is_load),
      .i_is_store   (e_is_store),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .o_wb_we      (wb_we),
      .o_wb_sel     (wb_sel),
      .o_wb_data    (wb_data),
      .o_nzp_cur    (nzp_cur),
      .o_wb_valid   (o_wb_valid),
      .o_wb_pc      (o_wb_pc),
      .o_wb_insn    (o_wb_insn),
      .o_nzp_we     (o_nzp_we),
      .o_nzp_bits   (o_nzp_bits)
   );

   // retire trace shows the register write port
   assign o_rf_we   = wb_we;
   assign o_rf_wsel = wb_sel;
   assign o_rf_data = wb_data;

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 3
) (
   output logic o_clk,
   output logic o_rst_n
);

   // free-running clock, first rising edge at half a period
   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) o_clk = ~o_clk;
      end
   end

   // reset asserts 1 ns into the run and spans the first rising edges
   initial begin
      o_rst_n = 1'b1;
      #1;
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      // released shortly after an edge, like the other inputs
      #1;
      o_rst_n = 1'b1;
   end

endmodule

/* testbench/tb_lc4_core.sv */
`timescale 1ns/10ps

module tb_lc4_core import lc4_pkg::*; ();

   localparam int PROG_LEN       = 24;
   localparam int MAX_ROWS       = 32;
   localparam int RETIRE_TIMEOUT = 20;
   localparam int RESET_TIMEOUT  = 10;

   // one expected retire with fields that follow the trace outputs
   typedef struct packed {
      word_t    pc;
      word_t    insn;
      logic     rf_we;
      reg_idx_t wsel;
      word_t    data;
      logic     nzp_we;
      nzp_t     nzp;
      logic     dmem_we;
      word_t    addr;
      word_t    wdata;
   } retire_row_t;

   logic        clk;
   logic        rst_n;
   word_t       o_pc;
   word_t       i_insn;
   word_t       o_dmem_addr;
   logic        o_dmem_we;
   word_t       o_dmem_wdata;
   word_t       i_dmem_rdata;
   logic        o_wb_valid;
   word_t       o_wb_pc;
   word_t       o_wb_insn;
   logic        o_rf_we;
   reg_idx_t    o_rf_wsel;
   word_t       o_rf_data;
   logic        o_nzp_we;
   nzp_t        o_nzp_bits;

   word_t       prog [PROG_LEN];
   word_t       dmem [256];
   retire_row_t exp_rows [MAX_ROWS];
   int          num_rows;
   int          error_count;
   int          check_count;
   int          timeout_count;
   // store seen mid-cycle and applied at the following rising edge
   logic        wr_pend;
   logic [7:0]  wr_addr;
   word_t       wr_data;

   tb_clock #(
      .PERIOD_NS    (10),
      .RESET_CYCLES (3)
   ) clock0 (
      .o_clk   (clk),
      .o_rst_n (rst_n)
   );

   lc4_core dut0 (
      .gwe          (clk),
      .i_rst_n      (rst_n),
      .o_pc         (o_pc),
      .i_insn       (i_insn),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .i_dmem_rdata (i_dmem_rdata),
      .o_wb_valid   (o_wb_valid),
      .o_wb_pc      (o_wb_pc),
      .o_wb_insn    (o_wb_insn),
      .o_rf_we      (o_rf_we),
      .o_rf_wsel    (o_rf_wsel),
      .o_rf_data    (o_rf_data),
      .o_nzp_we     (o_nzp_we),
      .o_nzp_bits   (o_nzp_bits)
   );

   // addresses outside the program read as BR with no condition bits
   function automatic word_t fetch_word(input word_t pc);
      word_t idx;
      idx = pc - DEFAULT_RESET_PC;
      if ($isunknown(pc) || idx >= PROG_LEN) begin
         fetch_word = 16'h0000;
      end else begin
         fetch_word = prog[idx];
      end
   endfunction

   // both memory models drive their data 1 ns after the rising edge
   always @(negedge clk) begin
      wr_pend = o_dmem_we;
      wr_addr = o_dmem_addr[7:0];
      wr_data = o_dmem_wdata;
   end

   always @(posedge clk) begin
      if (wr_pend === 1'b1) begin
         dmem[wr_addr] = wr_data;
      end
      #1;
      i_insn       = fetch_word(o_pc);
      i_dmem_rdata = dmem[o_dmem_addr[7:0]];
   end

   task automatic check_value(input string what, input word_t got, input word_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic fill_dmem();
      logic [7:0] a8;
      // inverted address in the high byte and address in the low byte
      for (int a = 0; a < 256; a++) begin
         a8      = a[7:0];
         dmem[a] = {~a8, a8};
      end
   endtask

   task automatic load_program();
      prog[0]  = 16'h9205;  // CONST   R1, #5
      prog[1]  = 16'h95FD;  // CONST   R2, #-3
      prog[2]  = 16'h1642;  // ADD     R3, R1, R2   distance 1 and 2
      prog[3]  = 16'h18D1;  // SUB     R4, R3, R1
      prog[4]  = 16'h1B23;  // ADD     R5, R4, #3   zero result
      prog[5]  = 16'hD312;  // HICONST R1, #0x12
      prog[6]  = 16'h5C43;  // AND     R6, R1, R3
      prog[7]  = 16'h5E93;  // OR      R7, R2, R3
      prog[8]  = 16'h5DDA;  // XOR     R6, R7, R2
      prog[9]  = 16'h5188;  // NOT     R0, R6
      prog[10] = 16'h5027;  // AND     R0, R0, #7
      prog[11] = 16'h1A3B;  // ADD     R5, R0, #-5
      prog[12] = 16'h720A;  // STR     R1, R0, #10
      prog[13] = 16'h640A;  // LDR     R2, R0, #10  reads the stored word
      prog[14] = 16'h1682;  // ADD     R3, R2, R2   load forwarded
      prog[15] = 16'h683B;  // LDR     R4, R0, #-5  untouched address 0
      prog[16] = 16'h0405;  // BRz     #5           not taken on flags n
      prog[17] = 16'h9C00;  // CONST   R6, #0
      prog[18] = 16'h0402;  // BRz     #2           taken to 8215
      prog[19] = 16'h9E01;  // CONST   R7, #1       squashed
      prog[20] = 16'h9E02;  // CONST   R7, #2       squashed
      prog[21] = 16'h1FE1;  // ADD     R7, R7, #1   zero only if both squashed
      prog[22] = 16'h0A04;  // BRnp    #4           not taken on flags z
      prog[23] = 16'h0FFF;  // BRnzp   #-1          loops on itself
   endtask

   task automatic push_row(input retire_row_t row);
      exp_rows[num_rows] = row;
      num_rows++;
   endtask

   task automatic add_reg_row(input word_t pc, input word_t insn, input reg_idx_t wsel,
                              input word_t data, input nzp_t nzp);
      retire_row_t row;
      row        = '0;
      row.pc     = pc;
      row.insn   = insn;
      row.rf_we  = 1'b1;
      row.wsel   = wsel;
      row.data   = data;
      row.nzp_we = 1'b1;
      row.nzp    = nzp;
      push_row(row);
   endtask

   task automatic add_store_row(input word_t pc, input word_t insn, input word_t addr,
                                input word_t wdata);
      retire_row_t row;
      row         = '0;
      row.pc      = pc;
      row.insn    = insn;
      row.dmem_we = 1'b1;
      row.addr    = addr;
      row.wdata   = wdata;
      push_row(row);
   endtask

   task automatic add_branch_row(input word_t pc, input word_t insn);
      retire_row_t row;
      row      = '0;
      row.pc   = pc;
      row.insn = insn;
      push_row(row);
   endtask

   task automatic load_expected();
      num_rows = 0;
      add_reg_row(16'h8200, 16'h9205, 3'd1, 16'h0005, 3'b001);
      add_reg_row(16'h8201, 16'h95FD, 3'd2, 16'hFFFD, 3'b100);
      add_reg_row(16'h8202, 16'h1642, 3'd3, 16'h0002, 3'b001);
      add_reg_row(16'h8203, 16'h18D1, 3'd4, 16'hFFFD, 3'b100);
      add_reg_row(16'h8204, 16'h1B23, 3'd5, 16'h0000, 3'b010);
      add_reg_row(16'h8205, 16'hD312, 3'd1, 16'h1205, 3'b001);
      add_reg_row(16'h8206, 16'h5C43, 3'd6, 16'h0000, 3'b010);
      add_reg_row(16'h8207, 16'h5E93, 3'd7, 16'hFFFF, 3'b100);
      add_reg_row(16'h8208, 16'h5DDA, 3'd6, 16'h0002, 3'b001);
      add_reg_row(16'h8209, 16'h5188, 3'd0, 16'hFFFD, 3'b100);
      add_reg_row(16'h820A, 16'h5027, 3'd0, 16'h0005, 3'b001);
      add_reg_row(16'h820B, 16'h1A3B, 3'd5, 16'h0000, 3'b010);
      add_store_row(16'h820C, 16'h720A, 16'h000F, 16'h1205);
      add_reg_row(16'h820D, 16'h640A, 3'd2, 16'h1205, 3'b001);
      add_reg_row(16'h820E, 16'h1682, 3'd3, 16'h240A, 3'b001);
      // fill word at address 0
      add_reg_row(16'h820F, 16'h683B, 3'd4, 16'hFF00, 3'b100);
      add_branch_row(16'h8210, 16'h0405);
      add_reg_row(16'h8211, 16'h9C00, 3'd6, 16'h0000, 3'b010);
      add_branch_row(16'h8212, 16'h0402);
      // 8213 and 8214 never retire
      add_reg_row(16'h8215, 16'h1FE1, 3'd7, 16'h0000, 3'b010);
      add_branch_row(16'h8216, 16'h0A04);
      add_branch_row(16'h8217, 16'h0FFF);
      // taken self loop comes back to its own pc
      add_branch_row(16'h8217, 16'h0FFF);
   endtask

   task automatic check_reset_outputs();
      check_value("reset o_pc", o_pc, DEFAULT_RESET_PC);
      check_value("reset o_wb_valid", o_wb_valid, 16'h0000);
      check_value("reset o_rf_we", o_rf_we, 16'h0000);
      check_value("reset o_nzp_we", o_nzp_we, 16'h0000);
      check_value("reset o_dmem_we", o_dmem_we, 16'h0000);
   endtask

   // one falling-edge sample per cycle
   task automatic wait_retire(output logic seen);
      int n;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < RETIRE_TIMEOUT) begin
         @(negedge clk);
         if (o_wb_valid === 1'b1) begin
            seen = 1'b1;
         end
         n++;
      end
   endtask

   task automatic check_row(input int idx);
      retire_row_t row;
      string       tag;
      row = exp_rows[idx];
      tag = $sformatf("row %0d", idx);
      check_value({tag, " pc"}, o_wb_pc, row.pc);
      check_value({tag, " insn"}, o_wb_insn, row.insn);
      check_value({tag, " rf_we"}, o_rf_we, row.rf_we);
      if (row.rf_we) begin
         check_value({tag, " rf_wsel"}, o_rf_wsel, row.wsel);
         check_value({tag, " rf_data"}, o_rf_data, row.data);
      end
      check_value({tag, " nzp_we"}, o_nzp_we, row.nzp_we);
      if (row.nzp_we) begin
         check_value({tag, " nzp_bits"}, o_nzp_bits, row.nzp);
      end
      check_value({tag, " dmem_we"}, o_dmem_we, row.dmem_we);
      if (row.dmem_we) begin
         check_value({tag, " dmem_addr"}, o_dmem_addr, row.addr);
         check_value({tag, " dmem_wdata"}, o_dmem_wdata, row.wdata);
      end
   endtask

   initial begin
      int          n;
      int          row_idx;
      logic        in_reset;
      logic        reset_seen;
      logic        seen;
      retire_row_t row;
      i_insn        = 16'h0000;
      i_dmem_rdata  = 16'h0000;
      wr_pend       = 1'b0;
      wr_addr       = 8'h00;
      wr_data       = 16'h0000;
      error_count   = 0;
      check_count   = 0;
      timeout_count = 0;
      load_program();
      load_expected();
      fill_dmem();

      // reset state from the first sample under reset
      // up to the first sample after release
      n          = 0;
      in_reset   = 1'b1;
      reset_seen = 1'b0;
      while (in_reset && n < RESET_TIMEOUT) begin
         @(negedge clk);
         if (rst_n === 1'b0) begin
            reset_seen = 1'b1;
         end
         if (reset_seen) begin
            check_reset_outputs();
            if (rst_n === 1'b1) begin
               in_reset = 1'b0;
            end
         end
         n++;
      end
      if (in_reset) begin
         $display("timeout: reset was not asserted and released within %0d cycles",
                  RESET_TIMEOUT);
         timeout_count++;
      end

      // one row per retired instruction in program order
      row_idx = 0;
      while (row_idx < num_rows && timeout_count == 0) begin
         wait_retire(seen);
         if (seen) begin
            check_row(row_idx);
         end else begin
            row = exp_rows[row_idx];
            $display("timeout: row %0d with pc %h did not retire within %0d cycles",
                     row_idx, row.pc, RETIRE_TIMEOUT);
            timeout_count++;
         end
         row_idx++;
      end

      $display("checks: %0d, errors: %0d, timeouts: %0d",
               check_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* files.f */
design/lc4_pkg.sv
design/lc4_regfile.sv
design/lc4_alu.sv
design/lc4_decode.sv
design/lc4_execute.sv
design/lc4_result.sv
design/lc4_core.sv
testbench/tb_clock.sv
testbench/tb_lc4_core.sv

/* Bender.yml */
package:
  name: lc4_core

sources:
  - files:
      - design/lc4_pkg.sv
      - design/lc4_regfile.sv
      - design/lc4_alu.sv
      - design/lc4_decode.sv
      - design/lc4_execute.sv
      - design/lc4_result.sv
      - design/lc4_core.sv
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/tb_lc4_core.sv
